// ==== hdl/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'hbfc00000

// pc and instruction width
`define XLEN 32

// cache geometry
`define NUM_WAYS 4
`define INDEX_BITS 7
`define OFFSET_BITS 5
`define TAG_BITS 20

// one line holds eight instructions
`define WORDS_PER_LINE 8
`define LINE_BITS 256

// replacement age per way
`define AGE_BITS 2

`endif

// ==== hdl/fetch_pkg.sv ====
`include "fetch_defines.svh"

package fetch_pkg;

	// fetch controller states
	typedef enum logic [2:0] {
		// deliver from the cache or raise a misaligned fetch
		LOOKUP,
		// line request held on the memory port
		REQ,
		// request accepted, line not back yet
		WAIT,
		// one cycle to write the line into the victim way
		FILL,
		// flushed miss, throw the returning line away
		DRAIN
	} fetch_state_e;

	// address fields
	typedef logic [`INDEX_BITS-1:0] index_t;
	typedef logic [`TAG_BITS-1:0] tag_t;

	// word 0 sits in the low bits
	typedef logic [`LINE_BITS-1:0] line_t;

	typedef logic [`AGE_BITS-1:0] age_t;
	typedef logic [`NUM_WAYS-1:0] way_vec_t;

endpackage

// ==== hdl/cache_lookup_if.sv ====
`timescale 1ns/1ps

interface cache_lookup_if;

	// set and tag of the access
	fetch_pkg::index_t index;
	fetch_pkg::tag_t tag;

	// level while a read is wanted
	logic lookup;

	// single-cycle pulses
	logic touch;
	logic fill;
	fetch_pkg::line_t fill_line;

	// combinational read result
	logic hit;
	fetch_pkg::line_t hit_line;

	modport ctrl (
		output index,
		output tag,
		output lookup,
		output touch,
		output fill,
		output fill_line,
		input hit,
		input hit_line
	);

	modport ways (
		input index,
		input tag,
		input lookup,
		input touch,
		input fill,
		input fill_line,
		output hit,
		output hit_line
	);

endinterface

// ==== hdl/pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module pc_gen (
	input logic clk,
	input logic resetn,
	input logic advance,
	input logic branch_taken,
	input logic [`XLEN-1:0] branch_target,
	input logic exc_valid,
	input logic [`XLEN-1:0] exc_pc,
	output logic [`XLEN-1:0] pc,
	output logic redirected
);

	logic [`XLEN-1:0] seq_pc;
	logic [`XLEN-1:0] next_pc;

	assign seq_pc = pc + `XLEN'd4;

	// exception entry beats branch beats sequential
	always_comb
	begin
		if (exc_valid)
			next_pc = exc_pc;
		else if (branch_taken)
			next_pc = branch_target;
		else
			next_pc = seq_pc;
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			pc <= `FETCH_RESET_PC;
			redirected <= 1'b0;
		end
		else
		begin
			// pulse one cycle after the exception entry was loaded
			redirected <= exc_valid;
			if (exc_valid || advance)
				pc <= next_pc;
		end
	end

endmodule

// ==== hdl/icache_ways.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module icache_ways (
	input logic clk,
	input logic resetn,
	cache_lookup_if.ways look
);

	// valid bits per set, everything else per way and set
	fetch_pkg::way_vec_t valid_q [2**`INDEX_BITS];
	fetch_pkg::tag_t tag_q [`NUM_WAYS][2**`INDEX_BITS];
	fetch_pkg::age_t age_q [`NUM_WAYS][2**`INDEX_BITS];
	fetch_pkg::line_t data_q [`NUM_WAYS][2**`INDEX_BITS];

	fetch_pkg::way_vec_t set_valid;
	fetch_pkg::way_vec_t hit_vec;
	fetch_pkg::age_t set_age [`NUM_WAYS];
	fetch_pkg::age_t hit_age;
	fetch_pkg::age_t age_next [`NUM_WAYS];
	logic [$clog2(`NUM_WAYS)-1:0] victim;
	logic victim_found;

	assign set_valid = valid_q[look.index];

	// tag compare across all ways of the set
	always_comb
	begin
		hit_vec = '0;
		hit_age = '0;
		look.hit_line = '0;
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			set_age[w] = age_q[w][look.index];
			hit_vec[w] = look.lookup && set_valid[w]
				&& (tag_q[w][look.index] == look.tag);
			if (hit_vec[w])
			begin
				look.hit_line = data_q[w][look.index];
				hit_age = set_age[w];
			end
		end
	end

	assign look.hit = |hit_vec;

	always_comb
	begin
		victim = '0;
		victim_found = 1'b0;
		// lowest-numbered empty way first
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			if (!victim_found && !set_valid[w])
			begin
				victim = w[$clog2(`NUM_WAYS)-1:0];
				victim_found = 1'b1;
			end
		end
		// otherwise the oldest way of a full set
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			if (!victim_found && (set_age[w] == '1))
			begin
				victim = w[$clog2(`NUM_WAYS)-1:0];
				victim_found = 1'b1;
			end
		end
	end

	// ages of valid ways stay a permutation of 0..n-1
	always_comb
	begin
		for (int w = 0; w < `NUM_WAYS; w++)
		begin
			age_next[w] = set_age[w];
			if (look.fill)
			begin
				if (w == victim)
					age_next[w] = '0;
				else if (set_valid[w])
					age_next[w] = set_age[w] + 1'b1;
			end
			else if (hit_vec[w])
				age_next[w] = '0;
			else if (set_valid[w] && (set_age[w] < hit_age))
				age_next[w] = set_age[w] + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			for (int s = 0; s < 2**`INDEX_BITS; s++)
				valid_q[s] <= '0;
		end
		else if (look.fill)
			valid_q[look.index][victim] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (look.fill)
		begin
			tag_q[victim][look.index] <= look.tag;
			data_q[victim][look.index] <= look.fill_line;
		end
		if (look.fill || look.touch)
		begin
			for (int w = 0; w < `NUM_WAYS; w++)
				age_q[w][look.index] <= age_next[w];
		end
	end

endmodule

// ==== hdl/fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_ctrl (
	input logic clk,
	input logic resetn,
	input logic [`XLEN-1:0] pc,
	input logic redirected,
	output logic advance,
	cache_lookup_if.ctrl look,
	input logic id_allow_in,
	input logic mem_launched,
	input logic mem_line_valid,
	input fetch_pkg::line_t mem_line,
	output logic mem_req,
	output logic [`XLEN-1:0] mem_addr,
	output logic if_valid,
	output logic [`XLEN-1:0] if_pc,
	output logic [`XLEN-1:0] if_inst,
	output logic if_addr_exc
);

	fetch_pkg::fetch_state_e state_q;
	fetch_pkg::fetch_state_e state_d;
	logic [`XLEN-1:0] miss_addr_q;
	fetch_pkg::line_t fill_line_q;
	logic [$clog2(`WORDS_PER_LINE)-1:0] word;
	logic misaligned;
	logic in_lookup;
	logic in_fill;

	assign word = pc[`OFFSET_BITS-1:2];
	assign misaligned = (pc[1:0] != 2'b00);
	assign in_lookup = (state_q == fetch_pkg::LOOKUP);
	assign in_fill = (state_q == fetch_pkg::FILL);

	// refill writes the set of the latched miss, lookups follow the pc
	assign look.index = in_fill ? miss_addr_q[`OFFSET_BITS +: `INDEX_BITS]
		: pc[`OFFSET_BITS +: `INDEX_BITS];
	assign look.tag = in_fill ? miss_addr_q[`XLEN-1 -: `TAG_BITS] : pc[`XLEN-1 -: `TAG_BITS];
	assign look.lookup = in_lookup && !misaligned;
	assign look.fill = in_fill && !redirected;
	assign look.fill_line = fill_line_q;

	// misaligned pc goes out straight away with a zero instruction
	assign if_valid = in_lookup && (misaligned || look.hit);
	assign if_pc = pc;
	assign if_addr_exc = misaligned;
	assign if_inst = misaligned ? '0 : look.hit_line[word*`XLEN +: `XLEN];

	assign advance = if_valid && id_allow_in;
	assign look.touch = advance && look.hit;

	// a flushed request is dropped before it launches
	assign mem_req = (state_q == fetch_pkg::REQ) && !redirected;
	assign mem_addr = miss_addr_q;

	always_comb
	begin
		state_d = state_q;
		unique case (state_q)
			fetch_pkg::LOOKUP:
				if (look.lookup && !look.hit)
					state_d = fetch_pkg::REQ;
			fetch_pkg::REQ:
				if (redirected)
					state_d = fetch_pkg::LOOKUP;
				else if (mem_launched)
					state_d = fetch_pkg::WAIT;
			fetch_pkg::WAIT:
				if (redirected)
					state_d = mem_line_valid ? fetch_pkg::LOOKUP : fetch_pkg::DRAIN;
				else if (mem_line_valid)
					state_d = fetch_pkg::FILL;
			fetch_pkg::FILL:
				state_d = fetch_pkg::LOOKUP;
			fetch_pkg::DRAIN:
				if (mem_line_valid)
					state_d = fetch_pkg::LOOKUP;
			default:
				state_d = fetch_pkg::LOOKUP;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
			state_q <= fetch_pkg::LOOKUP;
		else
			state_q <= state_d;
	end

	// line-aligned miss address and the returned line
	always_ff @(posedge clk)
	begin
		if (look.lookup && !look.hit)
			miss_addr_q <= {pc[`XLEN-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
		if ((state_q == fetch_pkg::WAIT) && mem_line_valid)
			fill_line_q <= mem_line;
	end

endmodule

// ==== hdl/ifetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module ifetch_top (
	input logic clk,
	input logic resetn,
	input logic branch_taken,
	input logic [`XLEN-1:0] branch_target,
	input logic exc_valid,
	input logic [`XLEN-1:0] exc_pc,
	input logic id_allow_in,
	input logic mem_launched,
	input logic mem_line_valid,
	input fetch_pkg::line_t mem_line,
	output logic if_valid,
	output logic [`XLEN-1:0] if_pc,
	output logic [`XLEN-1:0] if_inst,
	output logic if_addr_exc,
	output logic mem_req,
	output logic [`XLEN-1:0] mem_addr
);

	logic [`XLEN-1:0] pc;
	logic redirected;
	logic advance;

	// lookup and refill path between controller and line store
	cache_lookup_if look_if ();

	pc_gen pc_gen_i (
		.clk (clk),
		.resetn (resetn),
		.advance (advance),
		.branch_taken (branch_taken),
		.branch_target (branch_target),
		.exc_valid (exc_valid),
		.exc_pc (exc_pc),
		.pc (pc),
		.redirected (redirected)
	);

	icache_ways icache_ways_i (
		.clk (clk),
		.resetn (resetn),
		.look (look_if.ways)
	);

	fetch_ctrl fetch_ctrl_i (
		.clk (clk),
		.resetn (resetn),
		.pc (pc),
		.redirected (redirected),
		.advance (advance),
		.look (look_if.ctrl),
		.id_allow_in (id_allow_in),
		.mem_launched (mem_launched),
		.mem_line_valid (mem_line_valid),
		.mem_line (mem_line),
		.mem_req (mem_req),
		.mem_addr (mem_addr),
		.if_valid (if_valid),
		.if_pc (if_pc),
		.if_inst (if_inst),
		.if_addr_exc (if_addr_exc)
	);

endmodule

// ==== testbench/tb_ifetch.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module tb_ifetch;

	localparam int clk_period = 8;
	localparam int reset_cycles = 10;
	// refill worst case of req, launch 3, line 6, fill, lookup and slack
	localparam int miss_cycles = 16;
	localparam int max_bp = 4;
	localparam logic [1:0] kind_seq = 2'd0;
	localparam logic [1:0] kind_branch = 2'd1;
	localparam logic [1:0] kind_exc = 2'd2;

	logic clk;
	logic resetn;
	logic branch_taken;
	logic [`XLEN-1:0] branch_target;
	logic exc_valid;
	logic [`XLEN-1:0] exc_pc;
	logic id_allow_in;
	logic mem_launched;
	logic mem_line_valid;
	fetch_pkg::line_t mem_line;
	logic if_valid;
	logic [`XLEN-1:0] if_pc;
	logic [`XLEN-1:0] if_inst;
	logic if_addr_exc;
	logic mem_req;
	logic [`XLEN-1:0] mem_addr;

	// stimulus table with one entry per delivered instruction
	logic [1:0] row_kind [$];
	logic [31:0] row_target [$];
	int row_bp [$];
	logic [31:0] row_pc [$];
	logic row_exc [$];
	logic [31:0] row_inst [$];
	int row_reqs [$];

	integer seed = 32'h219baa81;
	int req_count;
	logic [31:0] req_addrs [$];
	int check_count;
	int error_count;
	int current_row;
	logic table_built;

	ifetch_top ifetch_top_i (
		.clk (clk),
		.resetn (resetn),
		.branch_taken (branch_taken),
		.branch_target (branch_target),
		.exc_valid (exc_valid),
		.exc_pc (exc_pc),
		.id_allow_in (id_allow_in),
		.mem_launched (mem_launched),
		.mem_line_valid (mem_line_valid),
		.mem_line (mem_line),
		.if_valid (if_valid),
		.if_pc (if_pc),
		.if_inst (if_inst),
		.if_addr_exc (if_addr_exc),
		.mem_req (mem_req),
		.mem_addr (mem_addr)
	);

	initial
		clk = 1'b0;

	always #(clk_period / 2) clk = ~clk;

	// every memory word holds the inverse of its own address
	function automatic fetch_pkg::line_t line_words(input logic [31:0] line_addr);
		fetch_pkg::line_t line;
		for (int w = 0; w < `WORDS_PER_LINE; w++)
			line[w*32 +: 32] = ~(line_addr + 32'(4 * w));
		return line;
	endfunction

	task automatic add_row(input logic [1:0] kind, input logic [31:0] target, input int bp,
		input logic [31:0] pc, input logic exc, input logic [31:0] inst, input int reqs);
		row_kind.push_back(kind);
		row_target.push_back(target);
		row_bp.push_back(bp);
		row_pc.push_back(pc);
		row_exc.push_back(exc);
		row_inst.push_back(inst);
		row_reqs.push_back(reqs);
	endtask

	// branch acts at this row's transfer and exception hits before its delivery
	task automatic build_table();
		add_row(kind_seq, 32'h0, 0, 32'hbfc00000, 1'b0, ~32'hbfc00000, 1);
		add_row(kind_seq, 32'h0, 2, 32'hbfc00004, 1'b0, ~32'hbfc00004, 1);
		add_row(kind_seq, 32'h0, 0, 32'hbfc00008, 1'b0, ~32'hbfc00008, 1);
		add_row(kind_seq, 32'h0, 0, 32'hbfc0000c, 1'b0, ~32'hbfc0000c, 1);
		add_row(kind_seq, 32'h0, 0, 32'hbfc00010, 1'b0, ~32'hbfc00010, 1);
		add_row(kind_seq, 32'h0, 0, 32'hbfc00014, 1'b0, ~32'hbfc00014, 1);
		add_row(kind_seq, 32'h0, 0, 32'hbfc00018, 1'b0, ~32'hbfc00018, 1);
		add_row(kind_seq, 32'h0, 0, 32'hbfc0001c, 1'b0, ~32'hbfc0001c, 1);
		add_row(kind_branch, 32'hbfc00014, 3, 32'hbfc00020, 1'b0, ~32'hbfc00020, 2);
		// loop body already cached
		add_row(kind_seq, 32'h0, 0, 32'hbfc00014, 1'b0, ~32'hbfc00014, 2);
		add_row(kind_seq, 32'h0, 0, 32'hbfc00018, 1'b0, ~32'hbfc00018, 2);
		add_row(kind_seq, 32'h0, 0, 32'hbfc0001c, 1'b0, ~32'hbfc0001c, 2);
		add_row(kind_branch, 32'h00010200, 0, 32'hbfc00020, 1'b0, ~32'hbfc00020, 2);
		// lines A to E all map to set 0x10
		add_row(kind_branch, 32'h00020200, 0, 32'h00010200, 1'b0, ~32'h00010200, 3);
		add_row(kind_branch, 32'h00030200, 0, 32'h00020200, 1'b0, ~32'h00020200, 4);
		add_row(kind_branch, 32'h00040200, 0, 32'h00030200, 1'b0, ~32'h00030200, 5);
		add_row(kind_branch, 32'h00010200, 0, 32'h00040200, 1'b0, ~32'h00040200, 6);
		add_row(kind_branch, 32'h00050200, 0, 32'h00010200, 1'b0, ~32'h00010200, 6);
		add_row(kind_branch, 32'h00010200, 0, 32'h00050200, 1'b0, ~32'h00050200, 7);
		add_row(kind_branch, 32'h00020200, 0, 32'h00010200, 1'b0, ~32'h00010200, 7);
		add_row(kind_branch, 32'h00060000, 0, 32'h00020200, 1'b0, ~32'h00020200, 8);
		// flushed miss on 0x00060000 and then a miss on the exception entry
		add_row(kind_exc, 32'hbfc00380, 0, 32'hbfc00380, 1'b0, ~32'hbfc00380, 10);
		add_row(kind_branch, 32'h00060000, 0, 32'hbfc00384, 1'b0, ~32'hbfc00384, 10);
		add_row(kind_branch, 32'h00060002, 0, 32'h00060000, 1'b0, ~32'h00060000, 11);
		add_row(kind_branch, 32'hbfc00000, 4, 32'h00060002, 1'b1, 32'h0, 11);
		add_row(kind_seq, 32'h0, 0, 32'hbfc00000, 1'b0, ~32'hbfc00000, 11);
		table_built = 1'b1;
	endtask

	task automatic check_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic wait_delivery();
		while (!if_valid)
			@(negedge clk);
	endtask

	// pulse the exception once the line request has been launched
	task automatic raise_exception(input logic [31:0] target);
		while (!mem_req)
			@(negedge clk);
		while (mem_req)
			@(negedge clk);
		exc_valid = 1'b1;
		exc_pc = target;
		@(negedge clk);
		exc_valid = 1'b0;
	endtask

	task automatic run_row(input int idx, inout int last_reqs);
		logic [31:0] held_pc;
		logic [31:0] held_inst;
		logic held_exc;
		int errors_before;
		int prev_reqs;
		errors_before = error_count;
		prev_reqs = (idx == 0) ? 0 : row_reqs[idx-1];
		branch_taken = (row_kind[idx] == kind_branch);
		branch_target = row_target[idx];
		// a hit or a misaligned pc goes out in the first cycle of the row
		if (row_kind[idx] == kind_exc)
			raise_exception(row_target[idx]);
		else if (row_reqs[idx] == prev_reqs)
			check_field("if_valid", 32'd1, 32'(if_valid));
		wait_delivery();
		check_field("if_pc", row_pc[idx], if_pc);
		check_field("if_addr_exc", 32'(row_exc[idx]), 32'(if_addr_exc));
		check_field("if_inst", row_inst[idx], if_inst);
		check_field("line requests", row_reqs[idx], req_count);
		if (req_count > last_reqs)
			check_field("mem_addr", {row_pc[idx][31:5], 5'b00000},
				req_addrs[req_addrs.size()-1]);
		last_reqs = req_count;
		held_pc = if_pc;
		held_inst = if_inst;
		held_exc = if_addr_exc;
		// outputs hold while the decode stage stalls
		repeat (row_bp[idx])
		begin
			@(negedge clk);
			check_field("if_valid", 32'd1, 32'(if_valid));
			check_field("if_pc", held_pc, if_pc);
			check_field("if_inst", held_inst, if_inst);
			check_field("if_addr_exc", 32'(held_exc), 32'(if_addr_exc));
		end
		id_allow_in = 1'b1;
		@(negedge clk);
		id_allow_in = 1'b0;
		branch_taken = 1'b0;
		if (error_count == errors_before)
			$display("row %0d pc %h: ok", idx, row_pc[idx]);
		else
			$display("row %0d pc %h: %0d errors", idx, row_pc[idx], error_count - errors_before);
	endtask

	initial
	begin : memory_model
		int launch_wait;
		int line_wait;
		logic [31:0] line_addr;
		logic dropped;
		forever
		begin
			@(negedge clk);
			if (resetn && mem_req)
			begin
				launch_wait = 1 + ($unsigned($random(seed)) % 3);
				line_addr = mem_addr;
				dropped = 1'b0;
				for (int i = 1; i < launch_wait; i++)
				begin
					@(negedge clk);
					if (!mem_req)
						dropped = 1'b1;
				end
				if (!dropped)
				begin
					req_count++;
					req_addrs.push_back(line_addr);
					mem_launched = 1'b1;
					@(negedge clk);
					mem_launched = 1'b0;
					line_wait = 2 + ($unsigned($random(seed)) % 5);
					repeat (line_wait - 1)
						@(negedge clk);
					mem_line = line_words(line_addr);
					mem_line_valid = 1'b1;
					@(negedge clk);
					mem_line_valid = 1'b0;
				end
			end
		end
	end

	initial
	begin : watchdog
		int limit_ns;
		wait (table_built);
		limit_ns = (row_pc.size() * (miss_cycles + max_bp) * 2 + reset_cycles) * clk_period;
		#(limit_ns);
		$display("watchdog: run timed out after %0d ns with row %0d unfinished",
			limit_ns, current_row);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin : stimulus
		int last_reqs;
		resetn = 1'b0;
		branch_taken = 1'b0;
		branch_target = '0;
		exc_valid = 1'b0;
		exc_pc = '0;
		id_allow_in = 1'b0;
		mem_launched = 1'b0;
		mem_line_valid = 1'b0;
		mem_line = '0;
		req_count = 0;
		check_count = 0;
		error_count = 0;
		current_row = 0;
		last_reqs = 0;
		table_built = 1'b0;
		build_table();
		repeat (reset_cycles)
			@(negedge clk);
		check_field("if_valid", 32'd0, 32'(if_valid));
		check_field("mem_req", 32'd0, 32'(mem_req));
		check_field("if_pc", `FETCH_RESET_PC, if_pc);
		resetn = 1'b1;
		for (int r = 0; r < row_pc.size(); r++)
		begin
			current_row = r;
			run_row(r, last_reqs);
		end
		$display("rows %0d, checks %0d, errors %0d, line requests %0d",
			row_pc.size(), check_count, error_count, req_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/cache_lookup_if.sv
hdl/pc_gen.sv
hdl/icache_ways.sv
hdl/fetch_ctrl.sv
hdl/ifetch_top.sv
testbench/tb_ifetch.sv

// ==== Bender.yml ====
package:
  name: ifetch

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/cache_lookup_if.sv
      - hdl/pc_gen.sv
      - hdl/icache_ways.sv
      - hdl/fetch_ctrl.sv
      - hdl/ifetch_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_ifetch.sv
